/* l2_config.svh */
/*
 * cache geometry and address window defines
 */
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// index width, 6 gives 64 tiles (valid range 4 to 12)
`define L2_INDEX_BITS 6

// tile payload width, one 128-bit tile per entry
`define L2_TILE_BITS 128

// cacheable RAM window, inclusive byte addresses
`define L2_RAM_LO 32'h0100_0000
`define L2_RAM_HI 32'h3FFF_FFFF

`endif

/* memBusPkg.sv */
/*
 * memory bus protocol: operation codes, status codes, request struct
 */
`default_nettype none

`include "l2_config.svh"

package memBusPkg;

	// operation codes, upper two bits nonzero marks an active operation
	typedef enum logic [4:0] {
		OPM_READY   = 5'b00000,
		OPM_RD_TILE = 5'b01111,
		OPM_WR_TILE = 5'b10111
	} memOpm_e;

	// status returned by the responder
	typedef enum logic [1:0] {
		OK_READY = 2'b00,
		OK_OK    = 2'b01,
		OK_HOLD  = 2'b10
	} memOk_e;

	typedef logic [`L2_TILE_BITS-1:0] busData_t;

	// held stable by the issuer until the status goes OK
	typedef struct packed {
		memOpm_e     opm;
		logic [31:0] addr;
		busData_t    data;
	} busReq_t;

	function automatic logic opmActive(memOpm_e opm);
		return opm[4:3] != 2'b00;
	endfunction

endpackage

`default_nettype wire

/* l2GeomPkg.sv */
/*
 * cache geometry: tile address union, store entry, fill result
 */
`default_nettype none

`include "l2_config.svh"

package l2GeomPkg;

	localparam int INDEX_BITS = `L2_INDEX_BITS;
	localparam int TAG_BITS   = 28 - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0]    tileIndex_t;
	typedef logic [27:0]              tileAddr_t;
	typedef logic [`L2_TILE_BITS-1:0] tileData_t;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		tileIndex_t          index;
		logic [3:0]          offset;
	} tileFields_t;

	// byte address, seen raw or split into tag/index/offset
	typedef union packed {
		logic [31:0] raw;
		tileFields_t fields;
	} tileAddr_u;

	typedef struct packed {
		logic      valid;
		logic      dirty;
		tileAddr_t tileAddr;
		tileData_t data;
	} tileEntry_t;

	typedef struct packed {
		logic      done;
		tileAddr_t tileAddr;
		tileData_t data;
	} fillResult_t;

endpackage

`default_nettype wire

/* tileStore.sv */
/*
 * tile store: tag, flag and data arrays
 * registered lookup with write forwarding, valid sweep after reset
 */
`timescale 1ns/1ns
`default_nettype none

module tileStore (
	input  logic                   clock,
	input  logic                   reset,
	input  l2GeomPkg::tileIndex_t  lookIndex,
	output l2GeomPkg::tileEntry_t  entry,
	input  logic                   storeWrite,
	input  l2GeomPkg::tileIndex_t  storeIndex,
	input  l2GeomPkg::tileEntry_t  storeEntry,
	output logic                   sweeping
);

	localparam int DEPTH = 1 << l2GeomPkg::INDEX_BITS;

	logic                  validArr [DEPTH];
	logic                  dirtyArr [DEPTH];
	l2GeomPkg::tileAddr_t  addrArr  [DEPTH];
	l2GeomPkg::tileData_t  dataArr  [DEPTH];

	l2GeomPkg::tileIndex_t sweepIndex;

	// one index cleared per cycle until the last one
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sweeping   <= 1'b1;
			sweepIndex <= '0;
		end
		else if (sweeping)
		begin
			sweepIndex <= sweepIndex + 1'b1;
			if (&sweepIndex)
				sweeping <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (storeWrite)
		begin
			validArr[storeIndex] <= storeEntry.valid;
			dirtyArr[storeIndex] <= storeEntry.dirty;
			addrArr[storeIndex]  <= storeEntry.tileAddr;
			dataArr[storeIndex]  <= storeEntry.data;
		end
		else if (sweeping)
			validArr[sweepIndex] <= 1'b0;
	end

	// lookup, a write to the same index wins
	always_ff @(posedge clock)
	begin
		if (storeWrite && (storeIndex == lookIndex))
			entry <= storeEntry;
		else
		begin
			entry.valid    <= validArr[lookIndex];
			entry.dirty    <= dirtyArr[lookIndex];
			entry.tileAddr <= addrArr[lookIndex];
			entry.data     <= dataArr[lookIndex];
		end
	end

	// the controller must keep the write port idle until the sweep ends
	storeIdleDuringSweep: assert property (
		@(posedge clock) disable iff (reset)
		sweeping |-> !storeWrite
	);

endmodule

`default_nettype wire

/* ddrSequencer.sv */
/*
 * DDR-side sequencer: dirty victim write-back, then tile fill
 */
`timescale 1ns/1ns
`default_nettype none

module ddrSequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   missStart,
	input  l2GeomPkg::tileEntry_t  victim,
	input  l2GeomPkg::tileAddr_t   fillAddr,
	output memBusPkg::busReq_t     ddrReq,
	input  memBusPkg::busData_t    ddrDataIn,
	input  memBusPkg::memOk_e      ddrOK,
	output l2GeomPkg::fillResult_t fill,
	output logic                   busy
);

	typedef enum logic [2:0] {
		IDLE,
		WB_ISSUE,
		WB_WAIT,
		FILL_ISSUE,
		FILL_WAIT,
		DONE
	} seqState_e;

	seqState_e            state;
	l2GeomPkg::tileAddr_t victimAddr;
	l2GeomPkg::tileData_t victimData;
	l2GeomPkg::tileAddr_t fillAddrReg;
	l2GeomPkg::tileData_t fillData;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= IDLE;
			ddrReq.opm <= memBusPkg::OPM_READY;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (missStart)
					begin
						victimAddr  <= victim.tileAddr;
						victimData  <= victim.data;
						fillAddrReg <= fillAddr;
						// clean or empty victim skips straight to the fill
						if (victim.valid && victim.dirty)
							state <= WB_ISSUE;
						else
							state <= FILL_ISSUE;
					end
				end

				WB_ISSUE:
				begin
					if (ddrOK == memBusPkg::OK_READY)
					begin
						ddrReq.opm  <= memBusPkg::OPM_WR_TILE;
						ddrReq.addr <= {victimAddr, 4'h0};
						ddrReq.data <= victimData;
						state       <= WB_WAIT;
					end
				end

				WB_WAIT:
				begin
					if (ddrOK == memBusPkg::OK_OK)
					begin
						ddrReq.opm <= memBusPkg::OPM_READY;
						state      <= FILL_ISSUE;
					end
				end

				// waits here for the DDR side to drop back to READY
				FILL_ISSUE:
				begin
					if (ddrOK == memBusPkg::OK_READY)
					begin
						ddrReq.opm  <= memBusPkg::OPM_RD_TILE;
						ddrReq.addr <= {fillAddrReg, 4'h0};
						ddrReq.data <= '0;
						state       <= FILL_WAIT;
					end
				end

				FILL_WAIT:
				begin
					if (ddrOK == memBusPkg::OK_OK)
					begin
						fillData   <= ddrDataIn;
						ddrReq.opm <= memBusPkg::OPM_READY;
						state      <= DONE;
					end
				end

				default:
					state <= IDLE;
			endcase
		end
	end

	// done is a single-cycle pulse on the way back to idle
	always_comb
	begin
		fill.done     = (state == DONE);
		fill.tileAddr = fillAddrReg;
		fill.data     = fillData;
		busy          = (state != IDLE);
	end

	ddrReqHeldOnHold: assert property (
		@(posedge clock) disable iff (reset)
		(ddrOK == memBusPkg::OK_HOLD) |=> $stable(ddrReq)
	);

	// controller must not start a second miss before this one is done
	noMissWhileBusy: assert property (
		@(posedge clock) disable iff (reset)
		missStart |-> !busy
	);

endmodule

`default_nettype wire

/* l2Controller.sv */
/*
 * request controller: request register, hit/miss decision,
 * bus status and store write source selection
 */
`timescale 1ns/1ns
`default_nettype none

`include "l2_config.svh"

module l2Controller (
	input  logic                   clock,
	input  logic                   reset,
	input  memBusPkg::busReq_t     memReq,
	output memBusPkg::busData_t    memDataOut,
	output memBusPkg::memOk_e      memOK,
	output l2GeomPkg::tileIndex_t  lookIndex,
	input  l2GeomPkg::tileEntry_t  entry,
	output logic                   storeWrite,
	output l2GeomPkg::tileIndex_t  storeIndex,
	output l2GeomPkg::tileEntry_t  storeEntry,
	input  logic                   sweeping,
	output logic                   missStart,
	output l2GeomPkg::tileEntry_t  victim,
	output l2GeomPkg::tileAddr_t   fillAddr,
	input  l2GeomPkg::fillResult_t fill,
	input  logic                   busy
);

	memBusPkg::busReq_t   reqReg;
	l2GeomPkg::tileAddr_u reqAddr;
	logic                 lookDone;
	logic                 missPending;
	logic                 isRead;
	logic                 isWrite;
	logic                 inRam;
	logic                 access;
	logic                 hit;
	logic                 hold;
	logic                 writeHit;

	always_comb
	begin
		reqAddr.raw = reqReg.addr;
		inRam       = (reqAddr.raw >= `L2_RAM_LO) && (reqAddr.raw <= `L2_RAM_HI);
		isRead      = (reqReg.opm == memBusPkg::OPM_RD_TILE);
		isWrite     = (reqReg.opm == memBusPkg::OPM_WR_TILE);
		access      = memBusPkg::opmActive(reqReg.opm) && inRam && (isRead || isWrite);

		// full tile address is kept, the upper part is the tag
		hit = entry.valid &&
			(entry.tileAddr[27:l2GeomPkg::INDEX_BITS] == reqAddr.fields.tag);

		hold = access &&
			(sweeping || busy || missPending || !lookDone || !hit);

		writeHit  = access && !hold && isWrite;
		missStart = access && lookDone && !sweeping && !missPending && !hit;

		lookIndex  = reqAddr.fields.index;
		victim     = entry;
		fillAddr   = reqAddr.raw[31:4];
		memDataOut = entry.data;

		if (!access)
			memOK = memBusPkg::OK_READY;
		else if (hold)
			memOK = memBusPkg::OK_HOLD;
		else
			memOK = memBusPkg::OK_OK;
	end

	// store write source: fill result first, then write hit
	always_comb
	begin
		storeWrite = 1'b0;
		storeIndex = reqAddr.fields.index;
		storeEntry = '{valid: 1'b1, dirty: 1'b1,
			tileAddr: reqAddr.raw[31:4], data: reqReg.data};

		if (fill.done)
		begin
			storeWrite = 1'b1;
			storeIndex = fill.tileAddr[l2GeomPkg::INDEX_BITS-1:0];
			storeEntry = '{valid: 1'b1, dirty: 1'b0,
				tileAddr: fill.tileAddr, data: fill.data};
		end
		else if (writeHit)
			storeWrite = 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqReg.opm  <= memBusPkg::OPM_READY;
			lookDone    <= 1'b0;
			missPending <= 1'b0;
		end
		else
		begin
			if (!hold)
				reqReg <= memReq;

			// entry is valid for reqReg one edge after capture
			lookDone <= hold && !sweeping;

			if (missStart)
				missPending <= 1'b1;
			else if (fill.done)
				missPending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* l2TileCache.sv */
/*
 * L2 tile cache top: store, DDR sequencer and request controller
 */
`timescale 1ns/1ns
`default_nettype none

module l2TileCache (
	input  logic                clock,
	input  logic                reset,
	input  memBusPkg::busReq_t  memReq,
	output memBusPkg::busData_t memDataOut,
	output memBusPkg::memOk_e   memOK,
	output memBusPkg::busReq_t  ddrReq,
	input  memBusPkg::busData_t ddrDataIn,
	input  memBusPkg::memOk_e   ddrOK
);

	l2GeomPkg::tileIndex_t  lookIndex;
	l2GeomPkg::tileEntry_t  entry;
	logic                   storeWrite;
	l2GeomPkg::tileIndex_t  storeIndex;
	l2GeomPkg::tileEntry_t  storeEntry;
	logic                   sweeping;
	logic                   missStart;
	l2GeomPkg::tileEntry_t  victim;
	l2GeomPkg::tileAddr_t   fillAddr;
	l2GeomPkg::fillResult_t fill;
	logic                   busy;

	tileStore store0 (
		.clock      (clock),
		.reset      (reset),
		.lookIndex  (lookIndex),
		.entry      (entry),
		.storeWrite (storeWrite),
		.storeIndex (storeIndex),
		.storeEntry (storeEntry),
		.sweeping   (sweeping)
	);

	ddrSequencer seq0 (
		.clock     (clock),
		.reset     (reset),
		.missStart (missStart),
		.victim    (victim),
		.fillAddr  (fillAddr),
		.ddrReq    (ddrReq),
		.ddrDataIn (ddrDataIn),
		.ddrOK     (ddrOK),
		.fill      (fill),
		.busy      (busy)
	);

	l2Controller ctrl0 (
		.clock      (clock),
		.reset      (reset),
		.memReq     (memReq),
		.memDataOut (memDataOut),
		.memOK      (memOK),
		.lookIndex  (lookIndex),
		.entry      (entry),
		.storeWrite (storeWrite),
		.storeIndex (storeIndex),
		.storeEntry (storeEntry),
		.sweeping   (sweeping),
		.missStart  (missStart),
		.victim     (victim),
		.fillAddr   (fillAddr),
		.fill       (fill),
		.busy       (busy)
	);

endmodule

`default_nettype wire

/* tbClock.sv */
/*
 * testbench clock and reset generator
 */
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// reset released on a falling edge, like every other input
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* ddrModel.sv */
/*
 * DDR responder for the testbench
 * sparse tile memory, random HOLD latency, log of tile writes
 */
`timescale 1ns/1ns
`default_nettype none

module ddrModel (
	input  logic                clock,
	input  logic                reset,
	input  memBusPkg::busReq_t  ddrReq,
	output memBusPkg::busData_t ddrDataIn,
	output memBusPkg::memOk_e   ddrOK,
	output int                  writeCount,
	output int                  readCount,
	output logic [31:0]         lastWriteAddr,
	output memBusPkg::busData_t lastWriteData
);

	memBusPkg::busData_t tiles [logic [27:0]];
	logic [31:0]         writeLogAddr [$];
	memBusPkg::busData_t writeLogData [$];

	// a tile never written reads as its tile address repeated four times
	function automatic memBusPkg::busData_t unwrittenTile(input logic [27:0] tileAddr);
		return {16'h0000, tileAddr, tileAddr, tileAddr, tileAddr};
	endfunction

	initial
	begin
		int          holdLeft;
		logic [27:0] tile;
		void'($urandom(49867));
		ddrOK         = memBusPkg::OK_READY;
		ddrDataIn     = '0;
		writeCount    = 0;
		readCount     = 0;
		lastWriteAddr = '0;
		lastWriteData = '0;
		holdLeft      = 0;
		forever
		begin
			@(negedge clock);
			tile = ddrReq.addr[31:4];
			if (reset)
			begin
				ddrOK    = memBusPkg::OK_READY;
				holdLeft = 0;
			end
			// OK lasts one cycle, then back to READY
			else if (ddrOK == memBusPkg::OK_OK)
				ddrOK = memBusPkg::OK_READY;
			else if (ddrOK == memBusPkg::OK_HOLD)
			begin
				if (holdLeft > 1)
					holdLeft--;
				else
				begin
					if (ddrReq.opm == memBusPkg::OPM_WR_TILE)
					begin
						tiles[tile] = ddrReq.data;
						writeLogAddr.push_back(ddrReq.addr);
						writeLogData.push_back(ddrReq.data);
						writeCount    = writeLogAddr.size();
						lastWriteAddr = writeLogAddr[$];
						lastWriteData = writeLogData[$];
					end
					else
					begin
						if (tiles.exists(tile))
							ddrDataIn = tiles[tile];
						else
							ddrDataIn = unwrittenTile(tile);
						readCount++;
					end
					ddrOK = memBusPkg::OK_OK;
				end
			end
			else if (ddrReq.opm == memBusPkg::OPM_RD_TILE ||
				ddrReq.opm == memBusPkg::OPM_WR_TILE)
			begin
				// 1 to 6 cycles of HOLD before the answer
				holdLeft = 1 + int'($urandom % 6);
				ddrOK    = memBusPkg::OK_HOLD;
			end
		end
	end

endmodule

`default_nettype wire

/* l2TileCacheTb.sv */
/*
 * testbench top for the L2 tile cache
 * pattern-driven requests, DDR traffic checks, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module l2TileCacheTb;

	localparam int WORDS_PER_LINE = 7;
	localparam int MAX_LINES      = 64;
	localparam int OK_TIMEOUT     = 1000;

	// one pattern line of kind, address, data, expected data and DDR counts
	typedef struct packed {
		logic [3:0]   kind;
		logic [31:0]  addr;
		logic [127:0] data;
		logic [127:0] expData;
		logic [7:0]   ddrWr;
		logic [7:0]   ddrRd;
		logic [31:0]  wbAddr;
	} patLine_t;

	logic                clock;
	logic                reset;
	memBusPkg::busReq_t  memReq;
	memBusPkg::busData_t memDataOut;
	memBusPkg::memOk_e   memOK;
	memBusPkg::busReq_t  ddrReq;
	memBusPkg::busData_t ddrDataIn;
	memBusPkg::memOk_e   ddrOK;
	int                  ddrWrites;
	int                  ddrReads;
	logic [31:0]         lastWriteAddr;
	memBusPkg::busData_t lastWriteData;

	logic [127:0] patMem [WORDS_PER_LINE*MAX_LINES];
	int           lineCount;
	int           linesRun;
	int           errorCount;
	logic         patternsLoaded;

	tbClock clockGen (.clock(clock), .reset(reset));

	ddrModel ddr0 (
		.clock         (clock),
		.reset         (reset),
		.ddrReq        (ddrReq),
		.ddrDataIn     (ddrDataIn),
		.ddrOK         (ddrOK),
		.writeCount    (ddrWrites),
		.readCount     (ddrReads),
		.lastWriteAddr (lastWriteAddr),
		.lastWriteData (lastWriteData)
	);

	l2TileCache dut0 (
		.clock      (clock),
		.reset      (reset),
		.memReq     (memReq),
		.memDataOut (memDataOut),
		.memOK      (memOK),
		.ddrReq     (ddrReq),
		.ddrDataIn  (ddrDataIn),
		.ddrOK      (ddrOK)
	);

	function automatic patLine_t fetchLine(input int lineNo);
		patLine_t p;
		int       base;
		base      = lineNo * WORDS_PER_LINE;
		p.kind    = patMem[base][3:0];
		p.addr    = patMem[base + 1][31:0];
		p.data    = patMem[base + 2];
		p.expData = patMem[base + 3];
		p.ddrWr   = patMem[base + 4][7:0];
		p.ddrRd   = patMem[base + 5][7:0];
		p.wbAddr  = patMem[base + 6][31:0];
		return p;
	endfunction

	task automatic reportValue(input string name, input logic [127:0] got,
		input logic [127:0] expected, input int lineNo);
		$display("FAIL %s: got %h expected %h (line %0d)", name, got, expected, lineNo);
		errorCount++;
	endtask

	task automatic reportText(input string what, input int lineNo);
		$display("line %0d: %s", lineNo, what);
		errorCount++;
	endtask

	task automatic runLine(input patLine_t p, input int lineNo);
		int   writesBefore;
		int   readsBefore;
		int   cycles;
		logic outside;
		outside = (p.kind == 4'd3) || (p.kind == 4'd4);
		@(negedge clock);
		if (memOK != memBusPkg::OK_READY)
			reportValue("memOK", 128'(memOK), 128'(memBusPkg::OK_READY), lineNo);
		writesBefore = ddrWrites;
		readsBefore  = ddrReads;
		memReq.opm   = (p.kind == 4'd2 || p.kind == 4'd4) ?
			memBusPkg::OPM_WR_TILE : memBusPkg::OPM_RD_TILE;
		memReq.addr  = p.addr;
		// reads carry no data, so a write-back cannot come from the bus
		memReq.data  = (p.kind == 4'd2 || p.kind == 4'd4) ? p.data : '0;
		cycles       = 0;
		if (outside)
		begin
			// status is combinational outside the window
			repeat (4)
			begin
				@(negedge clock);
				if (memOK != memBusPkg::OK_READY)
					reportValue("memOK", 128'(memOK), 128'(memBusPkg::OK_READY), lineNo);
			end
		end
		else
		begin
			do
			begin
				@(negedge clock);
				cycles++;
			end
			while (memOK != memBusPkg::OK_OK && cycles < OK_TIMEOUT);
			if (memOK != memBusPkg::OK_OK)
				reportText("the cache never answered OK", lineNo);
			else if (p.kind == 4'd1 && memDataOut != p.expData)
				reportValue("memDataOut", memDataOut, p.expData, lineNo);
		end
		memReq.opm = memBusPkg::OPM_READY;

		// READY again one cycle after the request drops
		@(negedge clock);
		if (memOK != memBusPkg::OK_READY)
			reportValue("memOK", 128'(memOK), 128'(memBusPkg::OK_READY), lineNo);
		if (ddrWrites - writesBefore != int'(p.ddrWr))
			reportValue("DDR WR_TILE count", 128'(ddrWrites - writesBefore),
				128'(p.ddrWr), lineNo);
		if (ddrReads - readsBefore != int'(p.ddrRd))
			reportValue("DDR RD_TILE count", 128'(ddrReads - readsBefore),
				128'(p.ddrRd), lineNo);
		if (p.ddrWr != 8'd0 && lastWriteAddr != p.wbAddr)
			reportValue("ddrReq.addr", 128'(lastWriteAddr), 128'(p.wbAddr), lineNo);
		if (p.ddrWr != 8'd0 && lastWriteData != p.data)
			reportValue("ddrReq.data", lastWriteData, p.data, lineNo);
	endtask

	initial
	begin
		patLine_t p;
		int       k;
		memReq.opm     = memBusPkg::OPM_READY;
		memReq.addr    = '0;
		memReq.data    = '0;
		errorCount     = 0;
		lineCount      = 0;
		linesRun       = 0;
		patternsLoaded = 1'b0;
		for (k = 0; k < WORDS_PER_LINE * MAX_LINES; k++)
			patMem[k] = '0;
		$readmemh("l2_patterns.txt", patMem);
		// a kind of zero ends the list
		while (lineCount < MAX_LINES && patMem[lineCount * WORDS_PER_LINE][3:0] != 4'h0)
			lineCount++;
		patternsLoaded = 1'b1;
		if (lineCount == 0)
			reportText("no pattern lines were read", 0);

		@(negedge reset);
		@(negedge clock);
		if (memOK != memBusPkg::OK_READY)
			reportValue("memOK", 128'(memOK), 128'(memBusPkg::OK_READY), 0);
		for (k = 0; k < lineCount; k++)
		begin
			p = fetchLine(k);
			runLine(p, k + 1);
			linesRun++;
		end

		$display("lines run: %0d, errors: %0d", linesRun, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog allows 2000 cycles per line plus one line's worth for reset
	initial
	begin
		wait (patternsLoaded);
		repeat ((lineCount + 1) * 2000) @(posedge clock);
		$display("watchdog: run still busy after %0d cycles", (lineCount + 1) * 2000);
		$display("lines run: %0d, errors: %0d", linesRun, errorCount + 1);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* l2_patterns.txt */
// kind addr data expData ddrWr ddrRd wbAddr, kind 1 read 2 write 3/4 read/write outside window
// data is write data, or the expected write-back data on a read that evicts
// first read of A, then a hit with no DDR traffic
1 01000040 00000000000000000000000000000000 00000100004010000401000040100004 0 1 00000000
1 01000040 00000000000000000000000000000000 00000100004010000401000040100004 0 0 00000000
// write B, read it back
2 02000080 DEADBEEF0123456789ABCDEFCAFEF00D 00000000000000000000000000000000 0 1 00000000
1 02000080 00000000000000000000000000000000 DEADBEEF0123456789ABCDEFCAFEF00D 0 0 00000000
// C shares the index with B and evicts it
1 03000080 DEADBEEF0123456789ABCDEFCAFEF00D 00000300008030000803000080300008 1 1 02000080
1 02000080 00000000000000000000000000000000 DEADBEEF0123456789ABCDEFCAFEF00D 0 1 00000000
// outside the RAM window
3 00001000 00000000000000000000000000000000 00000000000000000000000000000000 0 0 00000000
4 40000000 0F1E2D3C4B5A69788796A5B4C3D2E1F0 00000000000000000000000000000000 0 0 00000000
// write hit on a clean tile
2 01000040 0F1E2D3C4B5A69788796A5B4C3D2E1F0 00000000000000000000000000000000 0 0 00000000
1 01000040 00000000000000000000000000000000 0F1E2D3C4B5A69788796A5B4C3D2E1F0 0 0 00000000
// top of the window and index 3F
2 3FFFFFF0 11112222333344445555666677778888 00000000000000000000000000000000 0 1 00000000
1 12345670 00000000000000000000000000000000 00001234567123456712345671234567 0 1 00000000
1 200003F0 11112222333344445555666677778888 0000200003F200003F200003F200003F 1 1 3FFFFFF0
1 3FFFFFF0 00000000000000000000000000000000 11112222333344445555666677778888 0 1 00000000
// A dirty again, evicted by H, then both swap back
2 01000040 A5A5A5A55A5A5A5A00FF00FFFF00FF00 00000000000000000000000000000000 0 0 00000000
1 05000040 A5A5A5A55A5A5A5A00FF00FFFF00FF00 00000500004050000405000040500004 1 1 01000040
1 01000040 00000000000000000000000000000000 A5A5A5A55A5A5A5A00FF00FFFF00FF00 0 1 00000000
1 05000040 00000000000000000000000000000000 00000500004050000405000040500004 0 1 00000000

/* list.f */
+incdir+.
memBusPkg.sv
l2GeomPkg.sv
tileStore.sv
ddrSequencer.sv
l2Controller.sv
l2TileCache.sv
tbClock.sv
ddrModel.sv
l2TileCacheTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the L2 tile cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module l2TileCacheTb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vl2TileCacheTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0
